// ==== verilog.f ====
+incdir+test
hw/cache_pkg.sv
hw/cache.sv
hw/memory_arbiter.sv
hw/main_memory.sv
hw/memory_subsystem.sv
test/cache_tb.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = cache_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/cache_tb_ref.svh ====
`ifndef CACHE_TB_REF_SVH
`define CACHE_TB_REF_SVH

// ==========================================================================
// reference memory model
// ==========================================================================

// one entry per 32-bit word of main memory.
localparam int REF_WORDS = MEM_LINES * WORDS;
localparam int REF_IDX_BITS = $clog2(REF_WORDS);

logic [XLEN-1:0] ref_mem [REF_WORDS];

// power-on image, each word holds its own byte address.
function automatic void reset_model();
  for (int i = 0; i < REF_WORDS; i++) begin
    ref_mem[i] = XLEN'(i * (XLEN / 8));
  end
endfunction

// byte address to word slot.
// memory wraps at its size, so upper bits drop out.
function automatic int word_slot(logic [XLEN-1:0] addr);
  return int'(addr[BYTE_BITS +: REF_IDX_BITS]);
endfunction

// value a read of this address must return.
function automatic logic [XLEN-1:0] expected_read(logic [XLEN-1:0] addr);
  return ref_mem[word_slot(addr)];
endfunction

function automatic void record_write(logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
  ref_mem[word_slot(addr)] = data;
endfunction

`endif

// ==== test/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb import cache_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES = 8;
  localparam int DIRECTED_ACCESSES = 12;
  localparam int RANDOM_ACCESSES = 200;
  localparam int TOTAL_ACCESSES = DIRECTED_ACCESSES + N_PORTS * RANDOM_ACCESSES;
  localparam int CYCLE_LIMIT = 40 * TOTAL_ACCESSES + RESET_CYCLES;

  // tags that fit in one port's half of memory.
  localparam int HALF_TAGS = MEM_LINES / SETS / N_PORTS;
  localparam logic [XLEN-1:0] HALF_BYTES = XLEN'(MEM_LINES * WORDS * (XLEN / 8) / N_PORTS);

  logic     global_bus;
  logic     rst_n;
  cpu_req_t cpu_req [N_PORTS];
  cpu_rsp_t cpu_rsp [N_PORTS];

  int seed;
  int cycle_count = 0;
  int mismatch_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;
  int reads_checked = 0;

  logic            op_write [N_PORTS][RANDOM_ACCESSES];
  logic [XLEN-1:0] op_addr  [N_PORTS][RANDOM_ACCESSES];
  logic [XLEN-1:0] op_data  [N_PORTS][RANDOM_ACCESSES];

  `include "cache_tb_ref.svh"

  memory_subsystem i_dut (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp)
  );

  initial begin
    global_bus = 1'b0;
    forever #20 global_bus = ~global_bus;
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  // one request, held until the cache answers.
  task automatic access(int p, logic wr, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
    cpu_req_t req;
    req = '0;
    req.read = !wr;
    req.write = wr;
    req.addr.raw = addr;
    req.wdata = data;
    @(posedge global_bus);
    cpu_req[p] <= req;
    do begin
      @(posedge global_bus);
    end while (!cpu_rsp[p].ready);
    cpu_req[p] <= '0;
  endtask

  task automatic run_directed(int p);
    logic [XLEN-1:0] base;
    base = XLEN'(p) * HALF_BYTES;
    // cold miss.
    access(p, 1'b0, base + 32'h24, '0);
    access(p, 1'b1, base + 32'h48, 32'hcafe_0000 + XLEN'(p));
    access(p, 1'b0, base + 32'h48, '0);
    // 0x54 and 0xd4 share set 5, so the dirty line gets written back.
    access(p, 1'b1, base + 32'h54, 32'h1234_5600 + XLEN'(p));
    access(p, 1'b0, base + 32'hd4, '0);
    access(p, 1'b0, base + 32'h54, '0);
  endtask

  // only sets 0 and 1, so lines collide a lot.
  task automatic build_random_ops();
    logic [31:0] r;
    addr_u       a;
    for (int p = 0; p < N_PORTS; p++) begin
      for (int i = 0; i < RANDOM_ACCESSES; i++) begin
        r = $random(seed);
        a.raw = '0;
        a.fields.tag = TAG_BITS'(p * HALF_TAGS + int'(r[15:8]) % HALF_TAGS);
        a.fields.set = SET_BITS'(r[4]);
        a.fields.word = r[6:5];
        op_addr[p][i] = a.raw;
        op_write[p][i] = r[7];
        op_data[p][i] = $random(seed);
      end
    end
  endtask

  task automatic run_random(int p);
    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      access(p, op_write[p][i], op_addr[p][i], op_data[p][i]);
    end
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_errors + protocol_errors + timeout_errors;
    $display("errors: %0d mismatch, %0d protocol, %0d timeout (%0d reads checked)",
             mismatch_errors, protocol_errors, timeout_errors, reads_checked);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    seed = 32'hd3b7_715c;
    rst_n = 1'b0;
    for (int p = 0; p < N_PORTS; p++) begin
      cpu_req[p] = '0;
    end
    build_random_ops();
    repeat (RESET_CYCLES) @(posedge global_bus);
    rst_n <= 1'b1;
    // no requests yet, ready must stay low.
    repeat (IDLE_CYCLES) @(posedge global_bus);
    for (int p = 0; p < N_PORTS; p++) begin
      run_directed(p);
    end
    fork
      run_random(0);
      run_random(1);
    join
    repeat (2) @(posedge global_bus);
    finish_run();
  end

  // ==========================================================================
  // checking
  // ==========================================================================

  task automatic check_response(int p);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] expected;
    addr = cpu_req[p].addr.raw;
    assert (cpu_req[p].read || cpu_req[p].write) else begin
      protocol_errors++;
      $display("port %0d gave ready at %0t with no request pending", p, $time);
    end
    if (cpu_req[p].read) begin
      expected = expected_read(addr);
      reads_checked++;
      assert (cpu_rsp[p].rdata == expected) else begin
        mismatch_errors++;
        $display("mismatch at %0t: port %0d read of 0x%08h gave 0x%08h, expected 0x%08h",
                 $time, p, addr, cpu_rsp[p].rdata, expected);
      end
    end else if (cpu_req[p].write) begin
      record_write(addr, cpu_req[p].wdata);
    end
  endtask

  always @(posedge global_bus) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      for (int p = 0; p < N_PORTS; p++) begin
        if (cpu_rsp[p].ready) begin
          check_response(p);
        end
      end
    end
  end

  always @(posedge global_bus) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      timeout_errors++;
      $display("timeout after %0d cycles, a request never got its ready", cycle_count);
      finish_run();
    end
  end

endmodule

// ==== hw/memory_subsystem.sv ====
`timescale 1ns/1ns

module memory_subsystem import cache_pkg::*; (
  input  logic     global_bus,
  input  logic     rst_n,
  input  cpu_req_t cpu_req [N_PORTS],
  output cpu_rsp_t cpu_rsp [N_PORTS]
);

  // cache side of the arbiter.
  mem_req_t cache_mem_req [N_PORTS];
  mem_rsp_t cache_mem_rsp [N_PORTS];

  // memory side of the arbiter.
  mem_req_t arb_mem_req;
  mem_rsp_t arb_mem_rsp;

  for (genvar p = 0; p < N_PORTS; p++) begin : gen_cache
    cache i_cache (
      .global_bus (global_bus),
      .rst_n      (rst_n),
      .cpu_req    (cpu_req[p]),
      .cpu_rsp    (cpu_rsp[p]),
      .mem_req    (cache_mem_req[p]),
      .mem_rsp    (cache_mem_rsp[p])
    );
  end

  memory_arbiter i_arbiter (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .port_req   (cache_mem_req),
    .port_rsp   (cache_mem_rsp),
    .mem_req    (arb_mem_req),
    .mem_rsp    (arb_mem_rsp)
  );

  main_memory i_memory (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .mem_req    (arb_mem_req),
    .mem_rsp    (arb_mem_rsp)
  );

endmodule

// ==== hw/main_memory.sv ====
`timescale 1ns/1ns

module main_memory import cache_pkg::*; (
  input  logic     global_bus,
  input  logic     rst_n,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  line_t mem [MEM_LINES];

  logic                     busy;
  logic [LAT_BITS-1:0]      cnt;
  logic [LINE_IDX_BITS-1:0] line_idx;
  logic                     last_cycle;

  // line address modulo the array size.
  assign line_idx   = mem_req.line_addr[BYTE_BITS + WORD_BITS +: LINE_IDX_BITS];
  assign last_cycle = busy && (cnt == LAT_BITS'(MEM_LATENCY - 1));

  // ==========================================================================
  // latency counter
  // ==========================================================================

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      cnt          <= '0;
      mem_rsp.done <= 1'b0;
    end else begin
      mem_rsp.done <= 1'b0;
      if (last_cycle) begin
        busy         <= 1'b0;
        cnt          <= '0;
        mem_rsp.done <= 1'b1;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end else if (mem_req.valid && !mem_rsp.done) begin
        // the done cycle still shows the old valid.
        busy <= 1'b1;
        cnt  <= LAT_BITS'(1);
      end
    end
  end

  // ==========================================================================
  // storage
  // ==========================================================================

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int l = 0; l < MEM_LINES; l++) begin
        for (int w = 0; w < WORDS; w++) begin
          mem[l][w] <= XLEN'((l * WORDS + w) << BYTE_BITS);
        end
      end
    end else if (last_cycle && mem_req.write) begin
      mem[line_idx] <= mem_req.wline;
    end
  end

  always_ff @(posedge global_bus) begin
    if (last_cycle) begin
      mem_rsp.rline <= mem[line_idx];
    end
  end

endmodule

// ==== hw/memory_arbiter.sv ====
`timescale 1ns/1ns

module memory_arbiter import cache_pkg::*; (
  input  logic     global_bus,
  input  logic     rst_n,
  input  mem_req_t port_req [N_PORTS],
  output mem_rsp_t port_rsp [N_PORTS],
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  logic                 busy;
  logic [PORT_BITS-1:0] grant;
  logic [PORT_BITS-1:0] last_grant;
  logic [PORT_BITS-1:0] pick;
  logic [PORT_BITS-1:0] sel;
  logic                 any_valid;

  // search starts one past the last winner.
  always_comb begin
    int idx;
    pick      = '0;
    any_valid = 1'b0;
    for (int k = 1; k <= N_PORTS; k++) begin
      idx = (int'(last_grant) + k) % N_PORTS;
      if (!any_valid && port_req[idx].valid) begin
        any_valid = 1'b1;
        pick      = PORT_BITS'(idx);
      end
    end
  end

  // a free port is granted in the same cycle.
  assign sel     = busy ? grant : pick;
  assign mem_req = port_req[sel];

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      if (busy && (grant == PORT_BITS'(p))) begin
        port_rsp[p] = mem_rsp;
      end else begin
        port_rsp[p] = '0;
      end
    end
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      grant      <= '0;
      last_grant <= PORT_BITS'(N_PORTS - 1);
    end else if (busy) begin
      if (mem_rsp.done) begin
        busy       <= 1'b0;
        last_grant <= grant;
      end
    end else if (any_valid) begin
      busy  <= 1'b1;
      grant <= pick;
    end
  end

endmodule

// ==== hw/cache.sv ====
`timescale 1ns/1ns

module cache import cache_pkg::*; (
  input  logic     global_bus,
  input  logic     rst_n,
  input  cpu_req_t cpu_req,
  output cpu_rsp_t cpu_rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_write_back,
    st_fill,
    st_respond
  } fsm_state_e;

  fsm_state_e state;
  fsm_state_e state_next;

  // per-set storage.
  logic [TAG_BITS-1:0] tag_arr   [SETS];
  line_t               data_arr  [SETS];
  cache_state_e        state_arr [SETS];

  // request captured when it is sampled.
  cpu_req_t req_q;

  logic [SET_BITS-1:0]  set_idx;
  logic [WORD_BITS-1:0] word_idx;
  logic [TAG_BITS-1:0]  req_tag;
  logic                 hit;
  logic                 access;
  logic                 fill_done;

  assign set_idx  = req_q.addr.fields.set;
  assign word_idx = req_q.addr.fields.word;
  assign req_tag  = req_q.addr.fields.tag;

  assign hit = (state_arr[set_idx] != INVALID) && (tag_arr[set_idx] == req_tag);

  // a hit in lookup, or the replay after a fill.
  assign access    = ((state == st_lookup) && hit) || (state == st_respond);
  assign fill_done = (state == st_fill) && mem_rsp.done;

  // ==========================================================================
  // control FSM
  // ==========================================================================

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cpu_req.read || cpu_req.write) begin
          state_next = st_lookup;
        end
      end
      st_lookup: begin
        if (hit) begin
          state_next = st_idle;
        end else if (state_arr[set_idx] == MODIFIED) begin
          state_next = st_write_back;
        end else begin
          state_next = st_fill;
        end
      end
      st_write_back: begin
        if (mem_rsp.done) begin
          state_next = st_fill;
        end
      end
      st_fill: begin
        if (mem_rsp.done) begin
          state_next = st_respond;
        end
      end
      st_respond: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge global_bus) begin
    if (state == st_idle) begin
      req_q <= cpu_req;
    end
  end

  // ==========================================================================
  // line storage
  // ==========================================================================

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        state_arr[s] <= INVALID;
      end
    end else if (fill_done) begin
      state_arr[set_idx] <= VALID;
    end else if (access && req_q.write) begin
      state_arr[set_idx] <= MODIFIED;
    end
  end

  always_ff @(posedge global_bus) begin
    if (fill_done) begin
      tag_arr[set_idx]  <= req_tag;
      data_arr[set_idx] <= mem_rsp.rline;
    end else if (access && req_q.write) begin
      data_arr[set_idx][word_idx] <= req_q.wdata;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================

  always_comb begin
    cpu_rsp.ready = access;
    cpu_rsp.rdata = data_arr[set_idx][word_idx];
  end

  // victim address is rebuilt from the stored tag.
  always_comb begin
    mem_req = '0;
    case (state)
      st_write_back: begin
        mem_req.valid     = 1'b1;
        mem_req.write     = 1'b1;
        mem_req.line_addr = {tag_arr[set_idx], set_idx, {(WORD_BITS + BYTE_BITS){1'b0}}};
        mem_req.wline     = data_arr[set_idx];
      end
      st_fill: begin
        mem_req.valid     = 1'b1;
        mem_req.write     = 1'b0;
        mem_req.line_addr = {req_tag, set_idx, {(WORD_BITS + BYTE_BITS){1'b0}}};
      end
      default: begin
        mem_req = '0;
      end
    endcase
  end

endmodule

// ==== hw/cache_pkg.sv ====
package cache_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================

  localparam int XLEN = 32;
  localparam int SETS = 8;
  localparam int WORDS = 4;

  localparam int BYTE_BITS = $clog2(XLEN / 8);
  localparam int SET_BITS = $clog2(SETS);
  localparam int WORD_BITS = $clog2(WORDS);
  localparam int TAG_BITS = XLEN - SET_BITS - WORD_BITS - BYTE_BITS;

  // line index wraps at this size.
  localparam int MEM_LINES = 64;
  localparam int LINE_IDX_BITS = $clog2(MEM_LINES);

  // cycles from a granted request to done.
  localparam int MEM_LATENCY = 4;
  localparam int LAT_BITS = $clog2(MEM_LATENCY);

  localparam int N_PORTS = 2;
  localparam int PORT_BITS = $clog2(N_PORTS);

  // ==========================================================================
  // types
  // ==========================================================================

  typedef enum logic [1:0] {
    INVALID  = 2'b00,
    VALID    = 2'b01,
    MODIFIED = 2'b10
  } cache_state_e;

  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [SET_BITS-1:0]  set;
    logic [WORD_BITS-1:0] word;
    logic [BYTE_BITS-1:0] byte_sel;
  } addr_fields_t;

  // same word, seen raw or split into cache fields.
  typedef union packed {
    logic [XLEN-1:0] raw;
    addr_fields_t    fields;
  } addr_u;

  typedef logic [WORDS-1:0][XLEN-1:0] line_t;

  typedef struct packed {
    logic            read;
    logic            write;
    addr_u           addr;
    logic [XLEN-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic            ready;
    logic [XLEN-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] line_addr;
    line_t           wline;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    line_t rline;
  } mem_rsp_t;

endpackage
